// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = erx_core_tb
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD)

// ==== sources.f ====
+incdir+src
src/erx_pkg.sv
src/erx_remap.sv
src/erx_cfg.sv
src/erx_credit_port.sv
src/erx_distrib.sv
src/erx_core.sv
tests/erx_core_chk.sv
tests/erx_core_tb.sv

// ==== src/erx_cfg.sv ====
`timescale 1ns/1ps

module erx_cfg (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  cfg_access,
   input  erx_pkg::packet_t      cfg_packet,
   input  logic                  rx_count_inc,   // One per accepted link packet
   output erx_pkg::remap_mode_t  remap_mode,
   output logic [11:0]           remap_sel,
   output logic [11:0]           remap_pattern,
   output logic [31:0]           remap_base,
   output logic                  rsp_access,
   output erx_pkg::rsp_t         rsp_data
);

   erx_pkg::reg_idx_t reg_idx;    // Decoded from dstaddr[4:2]
   logic              reg_write;
   logic              reg_read;
   logic [31:0]       rx_count;   // Accepted link packets
   logic [31:0]       rd_value;   // Register read mux

   assign reg_idx   = erx_pkg::reg_idx_t'(cfg_packet.dstaddr[4:2]);
   assign reg_write = cfg_access & cfg_packet.write;
   assign reg_read  = cfg_access & ~cfg_packet.write;

   // Settings, visible the cycle after the write
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         remap_mode    <= erx_pkg::MAP_NONE;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end else if (reg_write) begin
         case (reg_idx)
            erx_pkg::REG_MODE:    remap_mode    <= erx_pkg::remap_mode_t'(cfg_packet.data[1:0]);
            erx_pkg::REG_SEL:     remap_sel     <= cfg_packet.data[11:0];
            erx_pkg::REG_PATTERN: remap_pattern <= cfg_packet.data[11:0];
            erx_pkg::REG_BASE:    remap_base    <= cfg_packet.data;
            default: begin
               // Count is read only, unknown index dropped
            end
         endcase
      end
   end

   // Link packet counter
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_count <= '0;
      end else if (rx_count_inc) begin
         rx_count <= rx_count + 32'd1;
      end
   end

   // Read mux, unused bits zero
   always_comb begin
      case (reg_idx)
         erx_pkg::REG_MODE:    rd_value = {30'd0, remap_mode};
         erx_pkg::REG_SEL:     rd_value = {20'd0, remap_sel};
         erx_pkg::REG_PATTERN: rd_value = {20'd0, remap_pattern};
         erx_pkg::REG_BASE:    rd_value = remap_base;
         erx_pkg::REG_COUNT:   rd_value = rx_count;
         default:              rd_value = '0;   // Unknown index
      endcase
   end

   // Response valid, one cycle after the read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_access <= 1'b0;
      end else begin
         rsp_access <= reg_read;
      end
   end

   // Response payload goes back to the requester
   always_ff @(posedge clk) begin
      if (reg_read) begin
         rsp_data.dstaddr <= cfg_packet.srcaddr;
         rsp_data.data    <= rd_value;
      end
   end

endmodule

// ==== src/erx_core.sv ====
`timescale 1ns/1ps

module erx_core (
   input  logic              clk,
   input  logic              arst_n,
   // Link side
   input  logic              rx_access,
   input  erx_pkg::packet_t  rx_packet,
   output logic              rx_wr_wait,
   output logic              rx_rd_wait,
   // Register port
   input  logic              cfg_access,
   input  erx_pkg::packet_t  cfg_packet,
   output logic              cfg_wait,
   // Write output
   output logic              rxwr_access,
   output erx_pkg::packet_t  rxwr_packet,
   input  logic              rxwr_credit,
   // Read-request output
   output logic              rxrd_access,
   output erx_pkg::packet_t  rxrd_packet,
   input  logic              rxrd_credit,
   // Read-response output
   output logic              rxrr_access,
   output erx_pkg::rsp_t     rxrr_packet,
   input  logic              rxrr_credit
);

   erx_pkg::remap_mode_t remap_mode;
   logic [11:0]          remap_sel;
   logic [11:0]          remap_pattern;
   logic [31:0]          remap_base;
   logic                 remap_access;   // Remap stage out
   erx_pkg::packet_t     remap_packet;
   logic                 rsp_access;     // Config response out
   erx_pkg::rsp_t        rsp_data;

   erx_remap u_remap (
      .clk           (clk),
      .arst_n        (arst_n),
      .rx_access     (rx_access),
      .rx_packet     (rx_packet),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .remap_access  (remap_access),
      .remap_packet  (remap_packet)
   );

   erx_cfg u_cfg (
      .clk           (clk),
      .arst_n        (arst_n),
      .cfg_access    (cfg_access),
      .cfg_packet    (cfg_packet),
      .rx_count_inc  (rx_access),      // Link never sends into a wait
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .rsp_access    (rsp_access),
      .rsp_data      (rsp_data)
   );

   erx_distrib u_distrib (
      .clk           (clk),
      .arst_n        (arst_n),
      .remap_access  (remap_access),
      .remap_packet  (remap_packet),
      .rsp_access    (rsp_access),
      .rsp_data      (rsp_data),
      .rxwr_credit   (rxwr_credit),
      .rxrd_credit   (rxrd_credit),
      .rxrr_credit   (rxrr_credit),
      .rxwr_access   (rxwr_access),
      .rxwr_packet   (rxwr_packet),
      .rxrd_access   (rxrd_access),
      .rxrd_packet   (rxrd_packet),
      .rxrr_access   (rxrr_access),
      .rxrr_packet   (rxrr_packet),
      .rx_wr_wait    (rx_wr_wait),
      .rx_rd_wait    (rx_rd_wait),
      .cfg_wait      (cfg_wait)
   );

endmodule

// ==== src/erx_credit_port.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_credit_port #(
   parameter type payload_t = erx_pkg::packet_t
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     credit,       // One credit back per high cycle
   output logic     wait_level,   // Queue near full
   output logic     access,
   output payload_t data
);

   localparam int DEPTH = `ERX_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int FW    = AW + 1;                       // Fill count incl. full
   localparam int CW    = $clog2(`ERX_CREDITS + 1);

   payload_t       mem [DEPTH];   // Queue storage
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [FW-1:0]  fill;          // Items queued
   logic [CW-1:0]  credits;       // Credits held
   logic           pop;

   // Circular increment, depth need not be a power of two
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
      ptr_inc = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Send while something queued and a credit held
   assign pop        = (fill != '0) && (credits != '0);
   assign access     = pop;
   assign data       = mem[rd_ptr];   // Head of queue
   assign wait_level = (fill >= FW'(`ERX_WAIT_LEVEL));

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         fill <= fill + FW'(push) - FW'(pop);   // Push and pop may coincide
      end
   end

   // Credit counter, return and spend in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credits <= CW'(`ERX_CREDITS);
      end else begin
         credits <= credits + CW'(credit) - CW'(pop);
      end
   end

endmodule

// ==== src/erx_distrib.sv ====
`timescale 1ns/1ps

module erx_distrib (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              remap_access,
   input  erx_pkg::packet_t  remap_packet,
   input  logic              rsp_access,
   input  erx_pkg::rsp_t     rsp_data,
   input  logic              rxwr_credit,
   input  logic              rxrd_credit,
   input  logic              rxrr_credit,
   output logic              rxwr_access,
   output erx_pkg::packet_t  rxwr_packet,
   output logic              rxrd_access,
   output erx_pkg::packet_t  rxrd_packet,
   output logic              rxrr_access,
   output erx_pkg::rsp_t     rxrr_packet,
   output logic              rx_wr_wait,
   output logic              rx_rd_wait,
   output logic              cfg_wait
);

   logic wr_push;   // Remapped write
   logic rd_push;   // Remapped read request

   // Sort by write bit
   assign wr_push = remap_access &  remap_packet.write;
   assign rd_push = remap_access & ~remap_packet.write;

   // Write queue
   erx_credit_port #(.payload_t(erx_pkg::packet_t)) u_wr_port (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (wr_push),
      .push_data  (remap_packet),
      .credit     (rxwr_credit),
      .wait_level (rx_wr_wait),    // Stalls link writes
      .access     (rxwr_access),
      .data       (rxwr_packet)
   );

   // Read-request queue
   erx_credit_port #(.payload_t(erx_pkg::packet_t)) u_rd_port (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (rd_push),
      .push_data  (remap_packet),
      .credit     (rxrd_credit),
      .wait_level (rx_rd_wait),    // Stalls link reads
      .access     (rxrd_access),
      .data       (rxrd_packet)
   );

   // Register read responses
   erx_credit_port #(.payload_t(erx_pkg::rsp_t)) u_rr_port (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (rsp_access),
      .push_data  (rsp_data),
      .credit     (rxrr_credit),
      .wait_level (cfg_wait),      // Holds off register reads
      .access     (rxrr_access),
      .data       (rxrr_packet)
   );

endmodule

// ==== src/erx_pkg.sv ====
package erx_pkg;

   // Mesh packet, msb first
   typedef struct packed {
      logic [31:0] srcaddr;   // Requester address, also the return address of a read
      logic [31:0] data;
      logic [31:0] dstaddr;   // Target address, remapped on receive
      logic [4:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;     // 1 = write, 0 = read request
   } packet_t;

   // Compact read response
   typedef struct packed {
      logic [31:0] dstaddr;   // Copied from request srcaddr
      logic [31:0] data;      // Register value
   } rsp_t;

   // Register index, dstaddr[4:2]
   typedef enum logic [2:0] {
      REG_MODE    = 3'd0,
      REG_SEL     = 3'd1,
      REG_PATTERN = 3'd2,
      REG_BASE    = 3'd3,
      REG_COUNT   = 3'd4     // Read only
   } reg_idx_t;

   // Remap mode; 3 is treated as no remap
   typedef enum logic [1:0] {
      MAP_NONE   = 2'd0,
      MAP_STATIC = 2'd1,
      MAP_OFFSET = 2'd2
   } remap_mode_t;

endpackage

// ==== src/erx_remap.sv ====
`timescale 1ns/1ps

module erx_remap (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  rx_access,
   input  erx_pkg::packet_t      rx_packet,
   input  erx_pkg::remap_mode_t  remap_mode,
   input  logic [11:0]           remap_sel,
   input  logic [11:0]           remap_pattern,
   input  logic [31:0]           remap_base,
   output logic                  remap_access,
   output erx_pkg::packet_t      remap_packet
);

   erx_pkg::packet_t packet_next;   // Packet after remap, before the register
   logic [11:0]      static_hi;     // Upper dstaddr bits for static mode

   // Selected bits from pattern, others kept
   assign static_hi = (remap_sel & remap_pattern) |
                      (~remap_sel & rx_packet.dstaddr[31:20]);

   always_comb begin
      packet_next = rx_packet;   // All other fields pass through
      case (remap_mode)
         erx_pkg::MAP_STATIC: begin
            packet_next.dstaddr[31:20] = static_hi;
         end
         erx_pkg::MAP_OFFSET: begin
            packet_next.dstaddr = rx_packet.dstaddr + remap_base;   // Wraps at 2^32
         end
         default: begin
            // No remap, mode 3 included
         end
      endcase
   end

   // Valid flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         remap_access <= 1'b0;
      end else begin
         remap_access <= rx_access;
      end
   end

   // Payload, loaded only on a valid beat
   always_ff @(posedge clk) begin
      if (rx_access) begin
         remap_packet <= packet_next;
      end
   end

endmodule

// ==== src/erx_settings.svh ====
`ifndef ERX_SETTINGS_SVH
`define ERX_SETTINGS_SVH

// Link packet size in bits
`define ERX_PW 104

// Entries in each output queue
`define ERX_FIFO_DEPTH 8

// Credits each output port holds out of reset
`define ERX_CREDITS 4

// Fill level that raises wait
// Two below depth, so a packet already in the remap register still fits
`define ERX_WAIT_LEVEL (`ERX_FIFO_DEPTH - 2)

`endif

// ==== tests/erx_core_chk.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_core_chk #(
   parameter int CW = $clog2(`ERX_CREDITS + 1),
   parameter int FW = $clog2(`ERX_FIFO_DEPTH) + 1
) (
   input logic          clk,
   input logic          arst_n,
   input logic          push,
   input logic          pop,
   input logic          credit,
   input logic          access,
   input logic [CW-1:0] credits,
   input logic [FW-1:0] fill
);

   localparam int AVW = CW + 1;

   logic [AVW-1:0] avail;   // Credits held, seen from the port pins

   // Returned credits in, sent items out
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         avail <= AVW'(`ERX_CREDITS);
      end else begin
         avail <= avail + AVW'(credit) - AVW'(access);
      end
   end

   // No send on an empty credit count
   a_access_credit: assert property (@(posedge clk) disable iff (!arst_n)
      access |-> (avail != '0))
      else $error("access with zero credits");

   // Downstream never returns more than it was given
   a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
      credits <= CW'(`ERX_CREDITS))
      else $error("credit count above limit");

   // Push into a full queue only with a pop in the same cycle
   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      (fill == FW'(`ERX_FIFO_DEPTH)) |-> (!push || pop))
      else $error("queue overflow");

endmodule

bind erx_credit_port erx_core_chk u_chk (
   .clk     (clk),
   .arst_n  (arst_n),
   .push    (push),
   .pop     (pop),
   .credit  (credit),
   .access  (access),
   .credits (credits),
   .fill    (fill)
);

// ==== tests/erx_core_tb.sv ====
`timescale 1ns/1ps
`include "erx_settings.svh"

module erx_core_tb;

   // Items sent: link packets and register accesses
   localparam int N_ITEMS = 3 * 16 + 15 + 20 + 300 + 40;
   localparam int LIMIT   = 20 * N_ITEMS + 200;

   logic clk;
   logic arst_n;
   logic rx_access;
   erx_pkg::packet_t rx_packet;
   logic rx_wr_wait;
   logic rx_rd_wait;
   logic cfg_access;
   erx_pkg::packet_t cfg_packet;
   logic cfg_wait;
   logic rxwr_access;
   erx_pkg::packet_t rxwr_packet;
   logic rxrd_access;
   erx_pkg::packet_t rxrd_packet;
   logic rxrr_access;
   erx_pkg::rsp_t rxrr_packet;
   logic [2:0] credit;             // wr, rd, rr
   logic [2:0] acc;
   logic [2:0] waits;              // Wait outputs, same port order
   logic [2:0] in_now;             // Items driven this cycle, per port
   logic [2:0] in_prev;            // Same, one cycle earlier

   erx_pkg::packet_t exp_wr[$];    // Expected items per port
   erx_pkg::packet_t exp_rd[$];
   erx_pkg::rsp_t    exp_rr[$];
   int   tb_credits[3];            // Model of DUT credit counters
   int   tb_fill[3];               // Model of DUT queue fill levels
   logic hold;                     // Downstream withholds credits
   logic [31:0] stim_state;
   logic [31:0] credit_state;
   int   err_value;
   int   err_other;
   int   cycles;
   int   link_sent;
   logic saw_wr_wait;

   // Register copy for expected values
   logic [1:0]  m_mode;
   logic [11:0] m_sel;
   logic [11:0] m_pat;
   logic [31:0] m_base;

   erx_core uut (
      .clk (clk), .arst_n (arst_n),
      .rx_access (rx_access), .rx_packet (rx_packet),
      .rx_wr_wait (rx_wr_wait), .rx_rd_wait (rx_rd_wait),
      .cfg_access (cfg_access), .cfg_packet (cfg_packet), .cfg_wait (cfg_wait),
      .rxwr_access (rxwr_access), .rxwr_packet (rxwr_packet), .rxwr_credit (credit[0]),
      .rxrd_access (rxrd_access), .rxrd_packet (rxrd_packet), .rxrd_credit (credit[1]),
      .rxrr_access (rxrr_access), .rxrr_packet (rxrr_packet), .rxrr_credit (credit[2])
   );

   assign acc    = {rxrr_access, rxrd_access, rxwr_access};
   assign waits  = {cfg_wait, rx_rd_wait, rx_wr_wait};
   assign in_now = {cfg_access & ~cfg_packet.write,
                    rx_access & ~rx_packet.write,
                    rx_access & rx_packet.write};

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      stim_state = xorshift(stim_state);
      return stim_state;
   endfunction

   function automatic erx_pkg::packet_t rand_packet(input logic wr);
      erx_pkg::packet_t p;
      logic [31:0] r;
      p.srcaddr  = next_rand();
      p.data     = next_rand();
      p.dstaddr  = next_rand();
      r          = next_rand();
      p.ctrlmode = r[4:0];
      p.datamode = r[6:5];
      p.write    = wr;
      return p;
   endfunction

   // Expected remap of one link packet
   function automatic erx_pkg::packet_t ref_remap(input erx_pkg::packet_t p);
      erx_pkg::packet_t q;
      q = p;
      if (m_mode == 2'd1) begin
         q.dstaddr[31:20] = (m_sel & m_pat) | (~m_sel & p.dstaddr[31:20]);
      end else if (m_mode == 2'd2) begin
         q.dstaddr = p.dstaddr + m_base;   // Mod 2^32
      end
      return q;
   endfunction

   function automatic logic [31:0] reg_value(input logic [2:0] idx);
      case (idx)
         3'd0: return {30'd0, m_mode};
         3'd1: return {20'd0, m_sel};
         3'd2: return {20'd0, m_pat};
         3'd3: return m_base;
         3'd4: return link_sent;
         default: return 32'd0;
      endcase
   endfunction

   task automatic put_idle();
      rx_access  <= 1'b0;
      cfg_access <= 1'b0;
   endtask

   task automatic put_link(input erx_pkg::packet_t p);
      rx_access  <= 1'b1;
      rx_packet  <= p;
      cfg_access <= 1'b0;
      if (p.write) exp_wr.push_back(ref_remap(p));
      else exp_rd.push_back(ref_remap(p));
      link_sent++;
   endtask

   // Honors the wait for the packet's kind
   task automatic drive_link(input erx_pkg::packet_t p);
      @(posedge clk);
      while (p.write ? rx_wr_wait : rx_rd_wait) begin
         put_idle();
         @(posedge clk);
      end
      put_link(p);
   endtask

   task automatic drive_cfg(input logic wr, input logic [2:0] idx, input logic [31:0] d);
      erx_pkg::packet_t c;
      erx_pkg::rsp_t r;
      c = rand_packet(wr);
      c.dstaddr[4:2] = idx;
      c.data = d;
      @(posedge clk);
      while (!wr && cfg_wait) begin   // Reads wait, writes never do
         put_idle();
         @(posedge clk);
      end
      rx_access  <= 1'b0;
      cfg_access <= 1'b1;
      cfg_packet <= c;
      if (wr) begin
         case (idx)
            3'd0: m_mode = d[1:0];
            3'd1: m_sel  = d[11:0];
            3'd2: m_pat  = d[11:0];
            3'd3: m_base = d;
            default: ;   // Read only or unknown
         endcase
      end else begin
         r.dstaddr = c.srcaddr;
         r.data    = reg_value(idx);
         exp_rr.push_back(r);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         put_idle();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Downstream returns credits at random
   always @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         credit_state = xorshift(credit_state);
         credit[i] <= arst_n && !hold && (tb_credits[i] < `ERX_CREDITS)
                      && (credit_state[1:0] != 2'd0);
      end
   end

   // Compare outputs mid-cycle
   always @(negedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < 3; i++) tb_credits[i] = `ERX_CREDITS;
         for (int i = 0; i < 3; i++) tb_fill[i] = 0;
         in_prev = '0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (acc[i] && tb_credits[i] == 0) begin
               err_other++;
               $display("Port %0d sent without a credit at %0t", i, $time);
            end
            if (waits[i] !== (tb_fill[i] >= `ERX_WAIT_LEVEL)) begin
               err_value++;
               $display("Fail %0t: wait of port %0d is %b at fill %0d",
                        $time, i, waits[i], tb_fill[i]);
            end
            tb_credits[i] = tb_credits[i] + int'(credit[i]) - int'(acc[i]);
            // Item driven last cycle lands in the queue at the next edge
            tb_fill[i] = tb_fill[i] + int'(in_prev[i]) - int'(acc[i]);
         end
         in_prev = in_now;
         if (rxwr_access) begin
            if (exp_wr.size() == 0) begin
               err_other++;
               $display("Unexpected write packet at %0t", $time);
            end else if (rxwr_packet !== exp_wr[0]) begin
               err_value++;
               $display("Fail %0t: rxwr %h, expected %h", $time, rxwr_packet, exp_wr[0]);
            end
            if (exp_wr.size() != 0) void'(exp_wr.pop_front());
         end
         if (rxrd_access) begin
            if (exp_rd.size() == 0) begin
               err_other++;
               $display("Unexpected read request at %0t", $time);
            end else if (rxrd_packet !== exp_rd[0]) begin
               err_value++;
               $display("Fail %0t: rxrd %h, expected %h", $time, rxrd_packet, exp_rd[0]);
            end
            if (exp_rd.size() != 0) void'(exp_rd.pop_front());
         end
         if (rxrr_access) begin
            if (exp_rr.size() == 0) begin
               err_other++;
               $display("Unexpected read response at %0t", $time);
            end else if (rxrr_packet !== exp_rr[0]) begin
               err_value++;
               $display("Fail %0t: rxrr %h, expected %h", $time, rxrr_packet, exp_rr[0]);
            end
            if (exp_rr.size() != 0) void'(exp_rr.pop_front());
         end
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout after %0d cycles, outputs stopped arriving", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      arst_n = 1'b0;
      rx_access = 1'b0;
      rx_packet = '0;
      cfg_access = 1'b0;
      cfg_packet = '0;
      credit = '0;
      hold = 1'b0;
      stim_state = 32'd31;
      credit_state = 32'd31;
      err_value = 0;
      err_other = 0;
      cycles = 0;
      link_sent = 0;
      saw_wr_wait = 1'b0;
      m_mode = '0;
      m_sel = '0;
      m_pat = '0;
      m_base = '0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      // Pass-through after reset
      repeat (16) drive_link(rand_packet(next_rand() % 2 == 0));

      // Static remap, then offset
      drive_cfg(1'b1, 3'd1, next_rand());
      drive_cfg(1'b1, 3'd2, next_rand());
      drive_cfg(1'b1, 3'd0, 32'd1);
      repeat (16) drive_link(rand_packet(next_rand() % 2 == 0));
      drive_cfg(1'b1, 3'd3, next_rand());
      drive_cfg(1'b1, 3'd0, 32'd2);
      repeat (16) drive_link(rand_packet(next_rand() % 2 == 0));

      // Register reads, ignored writes included
      drive_cfg(1'b1, 3'd4, 32'hffff_ffff);
      drive_cfg(1'b1, 3'd6, 32'h1234_5678);
      for (int i = 0; i < 8; i++) drive_cfg(1'b0, 3'(i), 32'd0);

      // Withheld credits fill the write queue
      idle(1);
      while (exp_wr.size() != 0 || exp_rd.size() != 0 || exp_rr.size() != 0) idle(1);
      hold <= 1'b1;
      repeat (20) begin
         @(posedge clk);
         if (rx_wr_wait) begin
            saw_wr_wait = 1'b1;
            put_idle();
         end else begin
            put_link(rand_packet(1'b1));
         end
      end
      idle(20);
      if (!saw_wr_wait) begin
         err_other++;
         $display("rx_wr_wait never rose while credits were withheld");
      end
      hold <= 1'b0;

      // Random mix of link traffic and register reads
      for (int n = 0, r = 0; n < 300 || r < 40;) begin
         if (r < 40 && (n >= 300 || next_rand() % 8 == 0)) begin
            drive_cfg(1'b0, 3'(next_rand() % 6), 32'd0);
            r++;
         end else begin
            drive_link(rand_packet(next_rand() % 2 == 0));
            n++;
         end
         if (next_rand() % 4 == 0) idle(1);
      end

      idle(1);
      while (exp_wr.size() != 0 || exp_rd.size() != 0 || exp_rr.size() != 0) idle(1);
      idle(10);
      $display("Errors: %0d wrong values, %0d other", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule
